//--- src/lsu_pkg.sv
package lsu_pkg;

    // Data path
    localparam int XLEN   = 64;
    localparam int STRB_W = XLEN / 8;

    // Word address split, byte offset bits are implied zero
    localparam int ADDR_W     = 13;
    localparam int INDEX_W    = 6;
    localparam int TAG_W      = ADDR_W - INDEX_W;
    localparam int BYTE_OFF_W = 3;

    // AXI4-Lite bus
    localparam int AXI_ADDR_W = 32;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic              is_store;
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   store_data;
        logic [STRB_W-1:0] store_mask;
    } lsu_req_t;

    typedef struct packed {
        logic [XLEN-1:0] load_data;
        logic            access_fault;
    } lsu_rsp_t;

    // Master driven
    typedef struct packed {
        logic [AXI_ADDR_W-1:0] araddr;
        logic                  arvalid;
        logic                  rready;
        logic [AXI_ADDR_W-1:0] awaddr;
        logic                  awvalid;
        logic [XLEN-1:0]       wdata;
        logic [STRB_W-1:0]     wstrb;
        logic                  wvalid;
        logic                  bready;
    } axil_m2s_t;

    // Slave driven
    typedef struct packed {
        logic            arready;
        logic            rvalid;
        logic [XLEN-1:0] rdata;
        logic [1:0]      rresp;
        logic            awready;
        logic            wready;
        logic            bvalid;
        logic [1:0]      bresp;
    } axil_s2m_t;

    typedef struct packed {
        logic              start;
        logic              is_store;
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   wdata;
        logic [STRB_W-1:0] wstrb;
    } bus_cmd_t;

    typedef struct packed {
        logic            done;
        logic [XLEN-1:0] data;
        logic [1:0]      resp;
    } bus_result_t;

endpackage

//--- src/lsu_request_stage.sv
`timescale 1ns/1ps

module lsu_request_stage (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req_valid,
    input  lsu_pkg::lsu_req_t               req,
    input  logic                            busy,
    output logic                            req_fire,
    output lsu_pkg::lsu_req_t               held_req,
    output logic [lsu_pkg::ADDR_W-1:0]      lookup_addr
);

    // Accept only while the unit is free
    assign req_fire = req_valid && !busy;

    // Request payload, captured on the accepting edge
    always_ff @(posedge clk) begin
        if (req_fire) begin
            held_req <= req;
        end
    end

    // While free the cache sees the incoming address, so the lookup
    // lands on the same edge that accepts the request
    assign lookup_addr = busy ? held_req.addr : req.addr;

    property p_fire_addr_known;
        @(posedge clk) disable iff (rst)
        req_fire |-> !$isunknown(req.addr);
    endproperty

    property p_fire_store_mask;
        @(posedge clk) disable iff (rst)
        req_fire && req.is_store |-> req.store_mask != '0;
    endproperty

    property p_fire_store_data_known;
        @(posedge clk) disable iff (rst)
        req_fire && req.is_store |-> !$isunknown(req.store_data);
    endproperty

    a_fire_addr_known: assert property (p_fire_addr_known)
        else $error("accepted request with unknown address");

    a_fire_store_mask: assert property (p_fire_store_mask)
        else $error("accepted store with empty byte mask");

    a_fire_store_data_known: assert property (p_fire_store_data_known)
        else $error("accepted store with unknown data");

endmodule

//--- src/dcache_array.sv
`timescale 1ns/1ps

module dcache_array (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [lsu_pkg::ADDR_W-1:0]      lookup_addr,
    output logic                            hit,
    output logic [lsu_pkg::XLEN-1:0]        rdata,
    input  logic                            wr_en,
    input  logic [lsu_pkg::ADDR_W-1:0]      wr_addr,
    input  logic [lsu_pkg::XLEN-1:0]        wr_data,
    input  logic [lsu_pkg::STRB_W-1:0]      wr_mask,
    input  logic                            wr_fill
);

    localparam int LINES = 1 << lsu_pkg::INDEX_W;

    logic [lsu_pkg::TAG_W-1:0] tag_mem [LINES];
    logic [lsu_pkg::XLEN-1:0]  data_mem [LINES];
    logic [LINES-1:0]          valid;

    logic [lsu_pkg::INDEX_W-1:0] rd_index;
    logic [lsu_pkg::TAG_W-1:0]   rd_tag;

    logic [lsu_pkg::INDEX_W-1:0] wr_index;
    logic [lsu_pkg::TAG_W-1:0]   wr_tag;
    logic                        wr_line_hit;
    logic [lsu_pkg::XLEN-1:0]    merged;

    assign wr_index = wr_addr[lsu_pkg::INDEX_W-1:0];
    assign wr_tag   = wr_addr[lsu_pkg::ADDR_W-1:lsu_pkg::INDEX_W];

    // Lookup address is registered, arrays are read after the edge.
    // A write on the lookup edge is therefore already visible.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_index <= '0;
            rd_tag   <= '0;
        end else begin
            rd_index <= lookup_addr[lsu_pkg::INDEX_W-1:0];
            rd_tag   <= lookup_addr[lsu_pkg::ADDR_W-1:lsu_pkg::INDEX_W];
        end
    end

    assign hit   = valid[rd_index] && (tag_mem[rd_index] == rd_tag);
    assign rdata = data_mem[rd_index];

    // Store merge only touches a valid line with the same tag
    assign wr_line_hit = valid[wr_index] && (tag_mem[wr_index] == wr_tag);

    always_comb begin
        merged = data_mem[wr_index];
        for (int b = 0; b < lsu_pkg::STRB_W; b++) begin
            if (wr_mask[b]) begin
                merged[b*8 +: 8] = wr_data[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (wr_en && wr_fill) begin
            valid[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && (wr_fill || wr_line_hit)) begin
            data_mem[wr_index] <= merged;
        end
        if (wr_en && wr_fill) begin
            tag_mem[wr_index] <= wr_tag;
        end
    end

    a_hit_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(hit))
        else $error("cache hit is unknown");

endmodule

//--- src/load_store_ctrl.sv
`timescale 1ns/1ps

module load_store_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req_fire,
    input  lsu_pkg::lsu_req_t               held_req,
    input  logic                            hit,
    input  logic [lsu_pkg::XLEN-1:0]        rdata,
    output logic                            wr_en,
    output logic [lsu_pkg::ADDR_W-1:0]      wr_addr,
    output logic [lsu_pkg::XLEN-1:0]        wr_data,
    output logic [lsu_pkg::STRB_W-1:0]      wr_mask,
    output logic                            wr_fill,
    output lsu_pkg::bus_cmd_t               cmd,
    input  lsu_pkg::bus_result_t            result,
    output logic                            busy,
    output logic                            done,
    output lsu_pkg::lsu_rsp_t               rsp
);

    typedef enum logic [1:0] {
        IDLE,
        CHECK,
        LOAD_WAIT,
        STORE_WAIT
    } state_t;

    state_t state;

    logic load_hit;
    logic waiting;
    logic resp_ok;

    assign load_hit = (state == CHECK) && !held_req.is_store && hit;
    assign waiting  = (state == LOAD_WAIT) || (state == STORE_WAIT);
    assign resp_ok  = result.resp == lsu_pkg::RESP_OKAY;

    // Misses and all stores go out on the bus
    assign cmd.start    = (state == CHECK) && (held_req.is_store || !hit);
    assign cmd.is_store = held_req.is_store;
    assign cmd.addr     = held_req.addr;
    assign cmd.wdata    = held_req.store_data;
    assign cmd.wstrb    = held_req.store_mask;

    always_comb begin
        done             = 1'b0;
        rsp.load_data    = '0;
        rsp.access_fault = 1'b0;
        case (state)
            CHECK: begin
                done          = load_hit;
                rsp.load_data = rdata;
            end
            LOAD_WAIT: begin
                done             = result.done;
                rsp.load_data    = result.data;
                rsp.access_fault = !resp_ok;
            end
            STORE_WAIT: begin
                done             = result.done;
                rsp.access_fault = !resp_ok;
            end
            default: begin
                done = 1'b0;
            end
        endcase
    end

    // Free again in the done cycle so a new request can be taken there
    assign busy = (state != IDLE) && !done;

    // Refill on a good read, store merge on a good write.
    // The cache itself drops the merge when the line is not present.
    assign wr_en   = waiting && result.done && resp_ok;
    assign wr_fill = state == LOAD_WAIT;
    assign wr_addr = held_req.addr;
    assign wr_data = (state == LOAD_WAIT) ? result.data : held_req.store_data;
    assign wr_mask = (state == LOAD_WAIT) ? '1 : held_req.store_mask;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req_fire) begin
                        state <= CHECK;
                    end
                end
                CHECK: begin
                    if (cmd.start) begin
                        state <= held_req.is_store ? STORE_WAIT : LOAD_WAIT;
                    end else if (!req_fire) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    if (result.done) begin
                        state <= req_fire ? CHECK : IDLE;
                    end
                end
            endcase
        end
    end

    a_no_done_idle: assert property (@(posedge clk) disable iff (rst)
        done |-> state != IDLE)
        else $error("done raised while idle");

    // Port must only answer a command that this FSM is waiting on
    a_result_when_waiting: assert property (@(posedge clk) disable iff (rst)
        result.done |-> waiting)
        else $error("bus result outside a wait state");

endmodule

//--- src/axil_master_port.sv
`timescale 1ns/1ps

module axil_master_port (
    input  logic                    clk,
    input  logic                    rst,
    input  lsu_pkg::bus_cmd_t       cmd,
    output lsu_pkg::bus_result_t    result,
    output lsu_pkg::axil_m2s_t      axil_out,
    input  lsu_pkg::axil_s2m_t      axil_in
);

    localparam int PAD_W = lsu_pkg::AXI_ADDR_W - lsu_pkg::ADDR_W - lsu_pkg::BYTE_OFF_W;

    logic ar_valid;
    logic r_ready;
    logic aw_valid;
    logic w_valid;
    logic b_ready;

    logic [lsu_pkg::AXI_ADDR_W-1:0] addr_q;
    logic [lsu_pkg::XLEN-1:0]       wdata_q;
    logic [lsu_pkg::STRB_W-1:0]     wstrb_q;

    logic rd_fire;
    logic wr_fire;

    assign rd_fire = axil_in.rvalid && r_ready;
    assign wr_fire = axil_in.bvalid && b_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_valid <= 1'b0;
            r_ready  <= 1'b0;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            b_ready  <= 1'b0;
        end else begin
            if (cmd.start && !cmd.is_store) begin
                ar_valid <= 1'b1;
                r_ready  <= 1'b1;
            end else begin
                if (axil_in.arready) begin
                    ar_valid <= 1'b0;
                end
                if (rd_fire) begin
                    r_ready <= 1'b0;
                end
            end
            // AW and W leave together but complete on their own
            if (cmd.start && cmd.is_store) begin
                aw_valid <= 1'b1;
                w_valid  <= 1'b1;
                b_ready  <= 1'b1;
            end else begin
                if (axil_in.awready) begin
                    aw_valid <= 1'b0;
                end
                if (axil_in.wready) begin
                    w_valid <= 1'b0;
                end
                if (wr_fire) begin
                    b_ready <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.start) begin
            addr_q  <= {{PAD_W{1'b0}}, cmd.addr, {lsu_pkg::BYTE_OFF_W{1'b0}}};
            wdata_q <= cmd.wdata;
            wstrb_q <= cmd.wstrb;
        end
    end

    assign axil_out.araddr  = addr_q;
    assign axil_out.arvalid = ar_valid;
    assign axil_out.rready  = r_ready;
    assign axil_out.awaddr  = addr_q;
    assign axil_out.awvalid = aw_valid;
    assign axil_out.wdata   = wdata_q;
    assign axil_out.wstrb   = wstrb_q;
    assign axil_out.wvalid  = w_valid;
    assign axil_out.bready  = b_ready;

    assign result.done = rd_fire || wr_fire;
    assign result.data = axil_in.rdata;
    assign result.resp = rd_fire ? axil_in.rresp : axil_in.bresp;

    // Payload must hold until the handshake, even if a new command shows up
    a_ar_stable: assert property (@(posedge clk) disable iff (rst)
        axil_out.arvalid && !axil_in.arready |=> $stable(axil_out.araddr))
        else $error("araddr changed while waiting for arready");

    a_aw_stable: assert property (@(posedge clk) disable iff (rst)
        axil_out.awvalid && !axil_in.awready |=> $stable(axil_out.awaddr))
        else $error("awaddr changed while waiting for awready");

    a_w_stable: assert property (@(posedge clk) disable iff (rst)
        axil_out.wvalid && !axil_in.wready |=> $stable({axil_out.wdata, axil_out.wstrb}))
        else $error("write data changed while waiting for wready");

endmodule

//--- src/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  lsu_pkg::lsu_req_t       req,
    output logic                    busy,
    output logic                    done,
    output lsu_pkg::lsu_rsp_t       rsp,
    output lsu_pkg::axil_m2s_t      m_axil_out,
    input  lsu_pkg::axil_s2m_t      m_axil_in
);

    logic                        req_fire;
    lsu_pkg::lsu_req_t           held_req;
    logic [lsu_pkg::ADDR_W-1:0]  lookup_addr;

    logic                        hit;
    logic [lsu_pkg::XLEN-1:0]    rdata;
    logic                        wr_en;
    logic [lsu_pkg::ADDR_W-1:0]  wr_addr;
    logic [lsu_pkg::XLEN-1:0]    wr_data;
    logic [lsu_pkg::STRB_W-1:0]  wr_mask;
    logic                        wr_fill;

    lsu_pkg::bus_cmd_t           cmd;
    lsu_pkg::bus_result_t        result;

    lsu_request_stage u_request (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req         (req),
        .busy        (busy),
        .req_fire    (req_fire),
        .held_req    (held_req),
        .lookup_addr (lookup_addr)
    );

    dcache_array u_dcache (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .rdata       (rdata),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_mask     (wr_mask),
        .wr_fill     (wr_fill)
    );

    load_store_ctrl u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .req_fire (req_fire),
        .held_req (held_req),
        .hit      (hit),
        .rdata    (rdata),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .wr_mask  (wr_mask),
        .wr_fill  (wr_fill),
        .cmd      (cmd),
        .result   (result),
        .busy     (busy),
        .done     (done),
        .rsp      (rsp)
    );

    axil_master_port u_axil (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .result   (result),
        .axil_out (m_axil_out),
        .axil_in  (m_axil_in)
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2.0) clk = ~clk;

endmodule

//--- tb/axil_mem_model.sv
`timescale 1ns/1ps

module axil_mem_model (
    input  logic                clk,
    input  lsu_pkg::axil_m2s_t  axil_out,
    output lsu_pkg::axil_s2m_t  axil_in,
    output logic                stuck
);

    localparam int WORDS    = 8192;
    localparam int ERR_BASE = 6144;
    localparam int TIMEOUT  = 64;

    logic [lsu_pkg::XLEN-1:0] mem [WORDS];
    logic [31:0] lfsr_state;

    logic arready, rvalid, awready, wready, bvalid;
    logic [lsu_pkg::XLEN-1:0] rdata;
    logic [1:0] rresp, bresp;
    logic read_stuck, write_stuck;

    assign axil_in.arready = arready;
    assign axil_in.rvalid  = rvalid;
    assign axil_in.rdata   = rdata;
    assign axil_in.rresp   = rresp;
    assign axil_in.awready = awready;
    assign axil_in.wready  = wready;
    assign axil_in.bvalid  = bvalid;
    assign axil_in.bresp   = bresp;
    assign stuck = read_stuck || write_stuck;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Zero to three idle cycles
    task automatic random_wait();
        int n;
        n = int'(rand_bits(2));
        repeat (n) @(posedge clk);
    endtask

    initial begin
        lfsr_state = 32'h36f2;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = {32'(i) * 32'h9e37_79b1, ~(32'(i) ^ 32'hc0de_0000)};
        end
    end

    initial begin : read_channel
        logic [12:0] a;
        int t;
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rresp = lsu_pkg::RESP_OKAY;
        read_stuck = 1'b0;
        forever begin
            @(negedge clk);
            if (axil_out.arvalid) begin
                a = axil_out.araddr[15:3];
                random_wait();
                @(posedge clk) arready <= 1'b1;
                @(posedge clk) arready <= 1'b0;
                random_wait();
                @(posedge clk);
                rvalid <= 1'b1;
                rdata <= (int'(a) >= ERR_BASE) ? '0 : mem[a];
                rresp <= (int'(a) >= ERR_BASE) ? lsu_pkg::RESP_SLVERR : lsu_pkg::RESP_OKAY;
                t = 0;
                do begin
                    @(negedge clk);
                    t++;
                end while (!axil_out.rready && t < TIMEOUT);
                if (!axil_out.rready) begin
                    $display("Memory model: rready never came for a read response");
                    read_stuck = 1'b1;
                end
                @(posedge clk) rvalid <= 1'b0;
            end
        end
    end

    initial begin : write_channel
        logic [12:0] a;
        logic [lsu_pkg::XLEN-1:0] d;
        logic [lsu_pkg::STRB_W-1:0] m;
        int t;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        bresp = lsu_pkg::RESP_OKAY;
        write_stuck = 1'b0;
        forever begin
            @(negedge clk);
            if (axil_out.awvalid && axil_out.wvalid) begin
                a = axil_out.awaddr[15:3];
                d = axil_out.wdata;
                m = axil_out.wstrb;
                random_wait();
                @(posedge clk) awready <= 1'b1;
                @(posedge clk) awready <= 1'b0;
                random_wait();
                @(posedge clk) wready <= 1'b1;
                @(posedge clk) wready <= 1'b0;
                // Error region ignores the write
                if (int'(a) < ERR_BASE) begin
                    for (int b = 0; b < lsu_pkg::STRB_W; b++) begin
                        if (m[b]) begin
                            mem[a][b*8 +: 8] = d[b*8 +: 8];
                        end
                    end
                end
                random_wait();
                @(posedge clk);
                bvalid <= 1'b1;
                bresp <= (int'(a) >= ERR_BASE) ? lsu_pkg::RESP_SLVERR : lsu_pkg::RESP_OKAY;
                t = 0;
                do begin
                    @(negedge clk);
                    t++;
                end while (!axil_out.bready && t < TIMEOUT);
                if (!axil_out.bready) begin
                    $display("Memory model: bready never came for a write response");
                    write_stuck = 1'b1;
                end
                @(posedge clk) bvalid <= 1'b0;
            end
        end
    end

endmodule

//--- tb/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

    localparam int DONE_TIMEOUT = 200;
    localparam int ERR_BASE     = 6144;
    localparam int LINES        = 1 << lsu_pkg::INDEX_W;

    logic clk;
    logic rst;
    logic req_valid;
    lsu_pkg::lsu_req_t req;
    logic busy;
    logic done;
    lsu_pkg::lsu_rsp_t rsp;
    lsu_pkg::axil_m2s_t m_axil_out;
    lsu_pkg::axil_s2m_t m_axil_in;
    logic bus_stuck;

    int errors = 0;
    int checks = 0;
    logic [31:0] lfsr_state = 32'h36f2;

    // Reference memory and cache
    logic [lsu_pkg::XLEN-1:0] ref_mem [8192];
    logic                     ref_valid [LINES];
    logic [lsu_pkg::TAG_W-1:0] ref_tag [LINES];
    logic [lsu_pkg::XLEN-1:0] ref_data [LINES];

    lsu_pkg::lsu_rsp_t exp_rsp_q[$];
    logic              exp_hit_q[$];

    tb_clock_gen #(.PERIOD(8.0)) u_clk (.clk(clk));

    axil_mem_model u_mem (
        .clk      (clk),
        .axil_out (m_axil_out),
        .axil_in  (m_axil_in),
        .stuck    (bus_stuck)
    );

    lsu_top UUT (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req        (req),
        .busy       (busy),
        .done       (done),
        .rsp        (rsp),
        .m_axil_out (m_axil_out),
        .m_axil_in  (m_axil_in)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                                input logic [63:0] new_word,
                                                input logic [7:0] mask);
        logic [63:0] w;
        w = old_word;
        for (int b = 0; b < 8; b++) begin
            if (mask[b]) begin
                w[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return w;
    endfunction

    // Expected response, and whether a load should hit
    function automatic lsu_pkg::lsu_rsp_t ref_access(input lsu_pkg::lsu_req_t r,
                                                     output logic exp_hit);
        lsu_pkg::lsu_rsp_t e;
        logic [lsu_pkg::INDEX_W-1:0] idx;
        logic [lsu_pkg::TAG_W-1:0] tag;
        logic cached;
        logic err;
        idx = r.addr[lsu_pkg::INDEX_W-1:0];
        tag = r.addr[lsu_pkg::ADDR_W-1:lsu_pkg::INDEX_W];
        cached = ref_valid[idx] && ref_tag[idx] == tag;
        err = int'(r.addr) >= ERR_BASE;
        e.load_data = '0;
        e.access_fault = 1'b0;
        exp_hit = !r.is_store && cached;
        if (exp_hit) begin
            e.load_data = ref_data[idx];
        end else if (err) begin
            e.access_fault = 1'b1;
        end else if (!r.is_store) begin
            e.load_data = ref_mem[r.addr];
            ref_valid[idx] = 1'b1;
            ref_tag[idx] = tag;
            ref_data[idx] = ref_mem[r.addr];
        end else begin
            ref_mem[r.addr] = merge_bytes(ref_mem[r.addr], r.store_data, r.store_mask);
            if (cached) begin
                ref_data[idx] = merge_bytes(ref_data[idx], r.store_data, r.store_mask);
            end
        end
        return e;
    endfunction

    task automatic check_rsp(input lsu_pkg::lsu_rsp_t got, input lsu_pkg::lsu_rsp_t exp);
        checks++;
        if (got.load_data !== exp.load_data) begin
            $display("ERROR rsp.load_data: got %h expected %h", got.load_data, exp.load_data);
            errors++;
        end
        if (got.access_fault !== exp.access_fault) begin
            $display("ERROR rsp.access_fault: got %h expected %h",
                     got.access_fault, exp.access_fault);
            errors++;
        end
    endtask

    task automatic check_hit_latency(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR hit_latency: got %h expected %h", got, exp);
            errors++;
        end
    endtask

    task automatic check_low(input string name, input logic got);
        checks++;
        if (got !== 1'b0) begin
            $display("ERROR %s: got %h expected 0", name, got);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("checks=%0d errors=%0d pending=%0d", checks, errors, exp_rsp_q.size());
        if (errors == 0 && exp_rsp_q.size() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic access(input logic is_store, input logic [12:0] addr,
                          input logic [63:0] data, input logic [7:0] mask);
        lsu_pkg::lsu_req_t r;
        lsu_pkg::lsu_rsp_t e;
        logic h;
        int t;
        r.is_store = is_store;
        r.addr = addr;
        r.store_data = data;
        r.store_mask = (mask == 8'h00) ? 8'h01 : mask;
        e = ref_access(r, h);
        exp_rsp_q.push_back(e);
        exp_hit_q.push_back(h);
        @(posedge clk);
        req_valid <= 1'b1;
        req <= r;
        @(posedge clk);
        req_valid <= 1'b0;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!done && t < DONE_TIMEOUT);
        if (!done) begin
            $display("Timed out waiting for done on address %h", addr);
            errors++;
            finish_run();
        end
    endtask

    // Comparing process, latency counted from the cycle that accepts
    int lat = 0;
    logic armed = 1'b0;
    always @(negedge clk) begin
        if (!rst) begin
            if (armed) begin
                lat++;
            end
            if (done) begin
                if (!armed || exp_rsp_q.size() == 0) begin
                    $display("Done pulse arrived with no request outstanding");
                    errors++;
                end else begin
                    check_rsp(rsp, exp_rsp_q.pop_front());
                    check_hit_latency(lat == 1, exp_hit_q.pop_front());
                end
                armed = 1'b0;
            end
            if (req_valid && !busy) begin
                armed = 1'b1;
                lat = 0;
            end
        end
    end

    initial begin
        logic [63:0] t3;
        logic [63:0] b3;
        logic [63:0] d;
        logic [63:0] m;
        logic [63:0] s;
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        for (int i = 0; i < 8192; i++) begin
            ref_mem[i] = {32'(i) * 32'h9e37_79b1, ~(32'(i) ^ 32'hc0de_0000)};
        end
        for (int i = 0; i < LINES; i++) begin
            ref_valid[i] = 1'b0;
            ref_tag[i] = '0;
            ref_data[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        check_low("busy", busy);
        check_low("done", done);
        check_low("arvalid", m_axil_out.arvalid);
        check_low("awvalid", m_axil_out.awvalid);
        check_low("wvalid", m_axil_out.wvalid);
        check_low("rready", m_axil_out.rready);
        check_low("bready", m_axil_out.bready);

        // Miss then hit
        access(1'b0, {7'd2, 6'd17}, '0, 8'h00);
        access(1'b0, {7'd2, 6'd17}, '0, 8'h00);

        // Store to a cached line and to an uncached one
        access(1'b1, {7'd2, 6'd17}, 64'h1122_3344_5566_7788, 8'b1010_0101);
        access(1'b0, {7'd2, 6'd17}, '0, 8'h00);
        access(1'b1, {7'd5, 6'd40}, 64'hdead_beef_cafe_f00d, 8'b0011_1100);
        access(1'b0, {7'd5, 6'd40}, '0, 8'h00);

        // Same index, different tags
        access(1'b0, {7'd3, 6'd9}, '0, 8'h00);
        access(1'b0, {7'd40, 6'd9}, '0, 8'h00);
        access(1'b0, {7'd3, 6'd9}, '0, 8'h00);
        access(1'b0, {7'd40, 6'd9}, '0, 8'h00);

        // Error region
        access(1'b0, {7'd100, 6'd12}, '0, 8'h00);
        access(1'b0, {7'd100, 6'd12}, '0, 8'h00);
        access(1'b1, {7'd110, 6'd3}, 64'h0123_4567_89ab_cdef, 8'hff);
        access(1'b0, {7'd110, 6'd3}, '0, 8'h00);

        // Random mix over few lines, top tags land in the error region
        for (int n = 0; n < 200; n++) begin
            s = rand_bits(1);
            t3 = rand_bits(3);
            b3 = rand_bits(3);
            d = rand_bits(64);
            m = rand_bits(8);
            access(s[0], {t3[2:0], 7'b000_0000, b3[2:0]}, d, m[7:0]);
        end

        repeat (4) @(negedge clk);
        if (bus_stuck) begin
            $display("Memory model saw a response that was never accepted");
            errors++;
        end
        finish_run();
    end

endmodule

//--- list.f
src/lsu_pkg.sv
src/lsu_request_stage.sv
src/dcache_array.sv
src/load_store_ctrl.sv
src/axil_master_port.sv
src/lsu_top.sv
tb/tb_clock_gen.sv
tb/axil_mem_model.sv
tb/lsu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f list.f --top-module lsu_tb -o lsu_sim \
    > sim.log 2>&1 && ./obj_dir/lsu_sim >> sim.log 2>&1 || { cat sim.log; exit 1; }

cat sim.log
grep -q "ALL CHECKS PASSED" sim.log || exit 1
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
